/* verilog.f */
logic/isa_pkg.sv
logic/fetch_pkg.sv
logic/fetch_control.sv
logic/inflight_counter.sv
logic/pc_gen.sv
logic/fetch_queue.sv
logic/fetch_top.sv
dv/fetch_clock.sv
dv/fetch_assertions.sv
dv/fetch_tb.sv

/* dv/fetch_tb.sv */
module fetch_tb;

    timeunit 1ns;
    timeprecision 100ps;

    logic clk;
    logic reset;
    logic ibus_req_valid;
    fetch_pkg::ibus_req_t ibus_req;
    logic ibus_req_ready;
    fetch_pkg::ibus_resp_t ibus_resp;
    isa_pkg::word_t predict_pc;
    fetch_pkg::prediction_t prediction;
    fetch_pkg::redirect_t redirect;
    logic out_valid;
    fetch_pkg::bundle_t out_bundle;
    logic out_ready;

    integer seed = 35341;
    fetch_pkg::prediction_t pred_table [16];
    // bus model with one entry per accepted request
    isa_pkg::word_t pend_addr [$];
    int pend_due [$];
    isa_pkg::word_t expected_pc = isa_pkg::reset_vector;
    isa_pkg::word_t expected_req_pc = isa_pkg::reset_vector;
    int cycle = 0;
    int bundles_seen = 0;
    int redirect_checks = 0;
    logic after_redirect = 1'b0;
    logic redirects_on = 1'b0;
    logic decode_hold = 1'b0;

    fetch_clock fetch_clock_inst (.clk(clk), .reset(reset));

    fetch_top fetch_top_inst (
        .clk(clk),
        .reset(reset),
        .ibus_req_valid(ibus_req_valid),
        .ibus_req(ibus_req),
        .ibus_req_ready(ibus_req_ready),
        .ibus_resp(ibus_resp),
        .predict_pc(predict_pc),
        .prediction(prediction),
        .redirect(redirect),
        .out_valid(out_valid),
        .out_bundle(out_bundle),
        .out_ready(out_ready)
    );

    bind fetch_top fetch_assertions fetch_assertions_inst (.*);

    // instruction word stored at a byte address
    function automatic isa_pkg::word_t instr_at(isa_pkg::word_t addr);
        return (addr * 32'h9e37_79b1) ^ 32'h0f0f_5a5a;
    endfunction

    function automatic isa_pkg::word_t random_target();
        return isa_pkg::reset_vector | (isa_pkg::word_t'($random(seed)) & 32'h0000_03fc);
    endfunction

    // predicted target if taken, else the following beat
    function automatic isa_pkg::word_t next_fetch_pc(isa_pkg::word_t pc);
        fetch_pkg::prediction_t pred;
        pred = pred_table[pc[5:2]];
        return pred.taken ? pred.target : (pc & ~32'd7) + 32'd8;
    endfunction

    task automatic fail_run(string reason);
        $display("test failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_value(string what, logic [63:0] actual, logic [63:0] expected);
        if (actual !== expected)
        begin
            $display("Error at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
            fail_run("value mismatch");
        end
    endtask

    task automatic check_bundle(fetch_pkg::bundle_t b);
        isa_pkg::word_t beat;
        fetch_pkg::prediction_t pred;
        beat = expected_pc & ~32'd7;
        pred = pred_table[expected_pc[5:2]];
        check_value("bundle pc", b.pc, expected_pc);
        check_value("slot mask", b.slot_mask, {1'b1, ~expected_pc[2]});
        if (!expected_pc[2])
        begin
            check_value("slot 0 instruction", b.instrs.slot0, instr_at(beat));
        end
        check_value("slot 1 instruction", b.instrs.slot1, instr_at(beat + 32'd4));
        check_value("predicted taken", b.pred_taken, pred.taken);
        if (pred.taken)
        begin
            check_value("predicted target", b.pred_target, pred.target);
        end
        expected_pc = next_fetch_pc(expected_pc);
        bundles_seen++;
        if (after_redirect)
        begin
            redirect_checks++;
            after_redirect = 1'b0;
        end
    endtask

    task automatic wait_for_count(ref int counter, input int goal, input int limit,
        input string what);
        int waited = 0;
        while (counter < goal)
        begin
            @(negedge clk);
            waited++;
            if (waited > limit)
            begin
                fail_run({"timed out waiting for ", what});
            end
        end
    endtask

    // full output queue with the bus idle and no request offered
    task automatic wait_for_fetch_stall(int limit);
        int waited = 0;
        int quiet = 0;
        while (quiet < 6)
        begin
            @(negedge clk);
            waited++;
            quiet = (out_valid && !ibus_req_valid && pend_addr.size() == 0) ? quiet + 1 : 0;
            if (waited > limit)
            begin
                fail_run("fetch did not stall while decode held out_ready low");
            end
        end
    endtask

    // predictor answers combinationally for predict_pc
    always_comb
    begin
        prediction = pred_table[predict_pc[5:2]];
    end

    always @(posedge clk)
    begin
        cycle++;
        if (reset)
        begin
            ibus_req_ready <= 1'b0;
            ibus_resp <= '0;
            redirect <= '0;
            out_ready <= 1'b0;
        end
        else
        begin
            if (fetch_top_inst.fetch_assertions_inst.failure_count != 0)
            begin
                fail_run("a bound assertion failed");
            end
            if (redirect.valid)
            begin
                check_value("ibus_req_valid in redirect cycle", ibus_req_valid, 0);
                check_value("out_valid in redirect cycle", out_valid, 0);
                expected_pc = redirect.target;
                expected_req_pc = redirect.target;
                after_redirect = 1'b1;
            end
            if (ibus_req_valid && ibus_req_ready)
            begin
                check_value("predict_pc at request", predict_pc, expected_req_pc);
                check_value("request address", ibus_req.addr, expected_req_pc & ~32'd7);
                expected_req_pc = next_fetch_pc(expected_req_pc);
                pend_addr.push_back(ibus_req.addr);
                pend_due.push_back(cycle + ($random(seed) & 3));
            end
            if (out_valid && out_ready)
            begin
                check_bundle(out_bundle);
            end
            ibus_req_ready <= (($random(seed) & 3) != 0);
            if (pend_addr.size() != 0 && pend_due[0] <= cycle)
            begin
                ibus_resp.data_ok <= 1'b1;
                ibus_resp.data <= {instr_at(pend_addr[0] + 32'd4), instr_at(pend_addr[0])};
                void'(pend_addr.pop_front());
                void'(pend_due.pop_front());
            end
            else
            begin
                ibus_resp <= {1'b0, $random(seed), $random(seed)};
            end
            if (redirects_on && !redirect.valid && (($random(seed) & 31) == 0))
            begin
                redirect <= {1'b1, random_target()};
            end
            else
            begin
                redirect <= '0;
            end
            out_ready <= !decode_hold && (($random(seed) & 3) != 0);
        end
    end

    initial
    begin
        int waited;
        waited = 0;
        ibus_req_ready = 1'b0;
        ibus_resp = '0;
        redirect = '0;
        out_ready = 1'b0;
        for (int i = 0; i < 16; i++)
        begin
            pred_table[i].taken = (($random(seed) & 3) == 0);
            pred_table[i].target = random_target();
        end
        while (reset !== 1'b0)
        begin
            @(negedge clk);
            waited++;
            if (waited > 100)
            begin
                fail_run("reset was never released");
            end
        end
        // first bundle is checked against the reset vector
        wait_for_count(bundles_seen, 1, 400, "the first bundle after reset");
        redirects_on = 1'b1;
        wait_for_count(bundles_seen, 300, 8000, "bundles under random redirects");
        wait_for_count(redirect_checks, 8, 8000, "bundles on redirected paths");
        redirects_on = 1'b0;
        for (int round = 0; round < 3; round++)
        begin
            decode_hold = 1'b1;
            wait_for_fetch_stall(400);
            decode_hold = 1'b0;
            wait_for_count(bundles_seen, bundles_seen + 24, 1000, "bundles after a decode stall");
        end
        if (fetch_top_inst.fetch_assertions_inst.failure_count == 0)
        begin
            $display("test passed");
            $finish;
        end
        else
        begin
            fail_run("a bound assertion failed");
        end
    end

endmodule

/* dv/fetch_assertions.sv */
module fetch_assertions (
    input logic clk,
    input logic reset,
    input fetch_pkg::redirect_t redirect,
    input logic ibus_req_valid,
    input logic ibus_req_ready,
    input fetch_pkg::ibus_req_t ibus_req,
    input logic out_valid,
    input logic [fetch_pkg::count_width-1:0] outstanding,
    input logic [fetch_pkg::count_width-1:0] bundle_count
);

    timeunit 1ns;
    timeprecision 100ps;

    int failure_count = 0;

    // every live request must own a slot downstream
    assert property (@(posedge clk) disable iff (reset)
        outstanding + bundle_count <= fetch_pkg::queue_depth)
    else
    begin
        failure_count++;
        $error("outstanding requests plus queued bundles exceed the queue depth");
    end

    assert property (@(posedge clk) disable iff (reset)
        redirect.valid |-> !ibus_req_valid && !out_valid)
    else
    begin
        failure_count++;
        $error("request or bundle offered in a redirect cycle");
    end

    // offered request holds until taken, unless a redirect kills it
    assert property (@(posedge clk) disable iff (reset)
        ibus_req_valid && !ibus_req_ready |=>
            redirect.valid || (ibus_req_valid && $stable(ibus_req)))
    else
    begin
        failure_count++;
        $error("request dropped or changed before it was accepted");
    end

endmodule

/* dv/fetch_clock.sv */
module fetch_clock (
    output logic clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #2 clk = ~clk;
        end
    end

    // reset spans the first 16 rising edges
    initial
    begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

/* logic/fetch_top.sv */
module fetch_top (
    input logic clk,
    input logic reset,
    output logic ibus_req_valid,
    output fetch_pkg::ibus_req_t ibus_req,
    input logic ibus_req_ready,
    input fetch_pkg::ibus_resp_t ibus_resp,
    output isa_pkg::word_t predict_pc,
    input fetch_pkg::prediction_t prediction,
    input fetch_pkg::redirect_t redirect,
    output logic out_valid,
    output fetch_pkg::bundle_t out_bundle,
    input logic out_ready
);

    logic issue;
    logic flush;
    logic req_fire;
    logic credit_ok;
    logic dropping;
    logic resp_keep;
    logic [fetch_pkg::count_width-1:0] outstanding;
    logic [fetch_pkg::count_width-1:0] bundle_count;
    logic [fetch_pkg::count_width:0] credit_used;

    fetch_pkg::inflight_t record;
    fetch_pkg::inflight_t head;
    logic head_valid;
    logic record_ready;
    logic bundle_ready;
    fetch_pkg::bundle_t bundle;

    // every live request owns a slot in the output queue
    assign credit_used = {1'b0, outstanding} + {1'b0, bundle_count};
    assign credit_ok = (credit_used < (fetch_pkg::count_width + 1)'(fetch_pkg::queue_depth))
        && record_ready;

    // old-path beats are thrown away
    assign resp_keep = ibus_resp.data_ok && !dropping && !flush && head_valid;

    always_comb
    begin
        bundle.pc = head.pc;
        bundle.slot_mask = head.slot_mask;
        bundle.instrs = ibus_resp.data;
        bundle.pred_taken = head.pred_taken;
        bundle.pred_target = head.pred_target;
    end

    fetch_control fetch_control_inst (
        .clk(clk),
        .reset(reset),
        .redirect(redirect),
        .credit_ok(credit_ok),
        .req_fire(req_fire),
        .issue(issue),
        .flush(flush)
    );

    inflight_counter inflight_counter_inst (
        .clk(clk),
        .reset(reset),
        .req_fire(req_fire),
        .resp_ok(ibus_resp.data_ok),
        .flush(flush),
        .outstanding(outstanding),
        .dropping(dropping)
    );

    pc_gen pc_gen_inst (
        .clk(clk),
        .reset(reset),
        .issue(issue),
        .ibus_req_ready(ibus_req_ready),
        .redirect(redirect),
        .prediction(prediction),
        .ibus_req_valid(ibus_req_valid),
        .ibus_req(ibus_req),
        .predict_pc(predict_pc),
        .record(record),
        .req_fire(req_fire)
    );

    fetch_queue #(
        .payload_t(fetch_pkg::inflight_t),
        .depth(fetch_pkg::queue_depth)
    ) inflight_queue (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .in_valid(req_fire),
        .in_data(record),
        .in_ready(record_ready),
        .out_valid(head_valid),
        .out_data(head),
        .out_ready(resp_keep && bundle_ready),
        .count()
    );

    fetch_queue #(
        .payload_t(fetch_pkg::bundle_t),
        .depth(fetch_pkg::queue_depth)
    ) bundle_queue (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .in_valid(resp_keep),
        .in_data(bundle),
        .in_ready(bundle_ready),
        .out_valid(out_valid),
        .out_data(out_bundle),
        .out_ready(out_ready),
        .count(bundle_count)
    );

endmodule

/* logic/fetch_queue.sv */
module fetch_queue #(
    parameter type payload_t = logic [31:0],
    parameter int depth = fetch_pkg::queue_depth
) (
    input logic clk,
    input logic reset,
    input logic flush,
    input logic in_valid,
    input payload_t in_data,
    output logic in_ready,
    output logic out_valid,
    output payload_t out_data,
    input logic out_ready,
    output logic [fetch_pkg::count_width-1:0] count
);

    typedef logic [$clog2(depth)-1:0] ptr_t;

    payload_t mem [depth];
    ptr_t wr_ptr;
    ptr_t rd_ptr;
    logic push;
    logic pop;

    assign in_ready = (count < fetch_pkg::count_width'(depth));
    // nothing leaves in a flush cycle
    assign out_valid = (count != '0) && !flush;
    assign out_data = mem[rd_ptr];

    assign push = in_valid && in_ready && !flush;
    assign pop = out_valid && out_ready;

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset || flush)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= (wr_ptr == ptr_t'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= (rd_ptr == ptr_t'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + push - pop;
        end
    end

endmodule

/* logic/pc_gen.sv */
module pc_gen (
    input logic clk,
    input logic reset,
    input logic issue,
    input logic ibus_req_ready,
    input fetch_pkg::redirect_t redirect,
    input fetch_pkg::prediction_t prediction,
    output logic ibus_req_valid,
    output fetch_pkg::ibus_req_t ibus_req,
    output isa_pkg::word_t predict_pc,
    output fetch_pkg::inflight_t record,
    output logic req_fire
);

    isa_pkg::word_t pc;
    isa_pkg::word_t beat_addr;
    isa_pkg::word_t next_pc;

    assign beat_addr = {pc[31:3], 3'b000};
    assign predict_pc = pc;

    assign ibus_req_valid = issue;
    assign ibus_req.addr = beat_addr;
    assign req_fire = issue && ibus_req_ready;

    // taken target, otherwise the next beat
    assign next_pc = prediction.taken ? prediction.target : beat_addr + 32'd8;

    always_comb
    begin
        record.pc = pc;
        // upper-half entry leaves slot 0 empty
        record.slot_mask = pc[2] ? 2'b10 : 2'b11;
        record.pred_taken = prediction.taken;
        record.pred_target = prediction.target;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc <= isa_pkg::reset_vector;
        end
        else if (redirect.valid)
        begin
            pc <= redirect.target;
        end
        else if (req_fire)
        begin
            pc <= next_pc;
        end
    end

endmodule

/* logic/inflight_counter.sv */
module inflight_counter (
    input logic clk,
    input logic reset,
    input logic req_fire,
    input logic resp_ok,
    input logic flush,
    output logic [fetch_pkg::count_width-1:0] outstanding,
    output logic dropping
);

    logic [fetch_pkg::count_width-1:0] drop_count;
    logic [fetch_pkg::count_width-1:0] outstanding_next;

    // every unanswered request, old path included
    always_comb
    begin
        outstanding_next = outstanding;
        if (req_fire && !resp_ok)
        begin
            outstanding_next = outstanding + 1'b1;
        end
        else if (!req_fire && resp_ok)
        begin
            outstanding_next = outstanding - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            outstanding <= '0;
            drop_count <= '0;
        end
        else
        begin
            outstanding <= outstanding_next;
            if (flush)
            begin
                // a beat landing right now is dropped by the flush itself
                drop_count <= outstanding - {{(fetch_pkg::count_width-1){1'b0}}, resp_ok};
            end
            else if (resp_ok && drop_count != '0)
            begin
                drop_count <= drop_count - 1'b1;
            end
        end
    end

    assign dropping = (drop_count != '0);

endmodule

/* logic/fetch_control.sv */
module fetch_control (
    input logic clk,
    input logic reset,
    input fetch_pkg::redirect_t redirect,
    input logic credit_ok,
    input logic req_fire,
    output logic issue,
    output logic flush
);

    typedef enum logic [1:0]
    {
        state_boot,
        state_run,
        state_starved
    } state_t;

    state_t state;
    state_t state_next;

    always_comb
    begin
        state_next = state;
        if (redirect.valid && state != state_boot)
        begin
            // restart on the new path, credits are rechecked next cycle
            state_next = state_run;
        end
        else
        begin
            case (state)
                state_boot:
                begin
                    state_next = state_run;
                end
                state_run:
                begin
                    if (!credit_ok && !req_fire)
                    begin
                        state_next = state_starved;
                    end
                end
                state_starved:
                begin
                    if (credit_ok)
                    begin
                        state_next = state_run;
                    end
                end
                default:
                begin
                    state_next = state_boot;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= state_boot;
        end
        else
        begin
            state <= state_next;
        end
    end

    // redirect wins over any request
    assign flush = redirect.valid;
    assign issue = (state == state_run) && credit_ok && !redirect.valid;

endmodule

/* logic/fetch_pkg.sv */
package fetch_pkg;

    // sizes both queues and the credit limit
    localparam int queue_depth = 4;
    localparam int count_width = 3;

    typedef struct packed
    {
        logic taken;
        isa_pkg::word_t target;
    } prediction_t;

    typedef struct packed
    {
        logic valid;
        isa_pkg::word_t target;
    } redirect_t;

    // beat address, always 8-byte aligned
    typedef struct packed
    {
        isa_pkg::word_t addr;
    } ibus_req_t;

    typedef struct packed
    {
        logic data_ok;
        logic [63:0] data;
    } ibus_resp_t;

    // one issued request waiting for its beat
    typedef struct packed
    {
        isa_pkg::word_t pc;
        logic [1:0] slot_mask;
        logic pred_taken;
        isa_pkg::word_t pred_target;
    } inflight_t;

    typedef struct packed
    {
        isa_pkg::word_t pc;
        logic [1:0] slot_mask;
        isa_pkg::instr_pair_t instrs;
        logic pred_taken;
        isa_pkg::word_t pred_target;
    } bundle_t;

endpackage

/* logic/isa_pkg.sv */
package isa_pkg;

    typedef logic [31:0] word_t;

    // one 64-bit beat, slot 0 in the low half
    typedef struct packed
    {
        word_t slot1;
        word_t slot0;
    } instr_pair_t;

    // boot rom entry point
    localparam word_t reset_vector = 32'hbfc0_0000;

endpackage
